/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing -j 0
TOP       := tb_mem_bus
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
+incdir+source
source/bus_pkg.sv
source/tenure_if.sv
source/mem_req_if.sv
source/bus_arbiter.sv
source/mem_target.sv
source/mem_store.sv
source/mem_bus_top.sv
tests/tb_mem_bus.sv

/* source/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             br1_n,
	input  logic             br2_n,
	input  logic             ts_n,
	input  logic             dbb_n,
	output logic             bg1_n,
	output logic             bg2_n,
	output logic             dbg1_n,
	output logic             dbg2_n,
	tenure_if.arb            ten,
	input  logic             pending,
	input  bus_pkg::cpu_id_t head_master,
	input  logic             queue_full
);
	import bus_pkg::*;

	// last master given the address bus, also drives round-robin priority
	cpu_id_t last_cpu;
	cpu_id_t data_owner;
	// set from ts_n until the target acknowledges the address
	logic    tenure_open;
	// set from the data grant until the beat completes
	logic    data_busy;
	logic    addr_free;
	logic    data_free;

	// a new address grant needs no grant outstanding, no open tenure and room in the queue
	assign addr_free = bg1_n && bg2_n && !tenure_open && !queue_full;
	assign data_free = dbg1_n && dbg2_n && !data_busy && dbb_n;

	assign ten.addr_master = last_cpu;
	assign ten.data_master = data_owner;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bg1_n       <= 1'b1;
			bg2_n       <= 1'b1;
			last_cpu    <= CPU2;
			tenure_open <= 1'b0;
		end else begin
			if (!ts_n) begin
				// the granted master has started its tenure, release the grant
				bg1_n <= 1'b1;
				bg2_n <= 1'b1;
			end else if (addr_free) begin
				// cpu1 wins unless cpu2 also asks and cpu1 went last
				if (!br1_n && (br2_n || last_cpu == CPU2)) begin
					bg1_n    <= 1'b0;
					last_cpu <= CPU1;
				end else if (!br2_n) begin
					bg2_n    <= 1'b0;
					last_cpu <= CPU2;
				end
			end
			if (!ts_n)
				tenure_open <= 1'b1;
			else if (ten.addr_done)
				tenure_open <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dbg1_n     <= 1'b1;
			dbg2_n     <= 1'b1;
			data_owner <= CPU1;
			data_busy  <= 1'b0;
		end else begin
			if (!dbg1_n || !dbg2_n) begin
				// record the owner before dbb_n falls so the target sees it in the first beat
				if (dbb_n)
					data_owner <= !dbg1_n ? CPU1 : CPU2;
				else begin
					dbg1_n <= 1'b1;
					dbg2_n <= 1'b1;
				end
			end else if (pending && data_free) begin
				// data tenures run in address order, so the queue head gets the bus
				if (head_master == CPU1)
					dbg1_n <= 1'b0;
				else
					dbg2_n <= 1'b0;
				data_busy <= 1'b1;
			end
			if (ten.data_done)
				data_busy <= 1'b0;
		end
	end

endmodule

/* source/bus_defs.svh */
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// word address width on the bus, one address per memory word
`define BUS_ADDR_W 8

// width of the data bus for a single-beat transfer
`define BUS_DATA_W 32

// number of words held by the memory target
`define MEM_DEPTH 256

// earliest cycle after ts_n in which aack_n may be asserted
// ta_n is held back by the same window when a snoop could still cancel the tenure
`define AACK_MIN_DELAY 3

// start value of the wait-state LFSR, must never be zero
`define LFSR_SEED 16'hace1

`endif

/* source/bus_pkg.sv */
package bus_pkg;

	// progress of one address tenure inside the memory target
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		// first cycle after ts_n, aack_n is never allowed here
		DELAY     = 2'd1,
		// the LFSR picks how long the tenure stays here
		AACK_WAIT = 2'd2,
		// the single cycle with aack_n low
		AACK      = 2'd3
	} addr_state_t;

	// transfer type codes seen on tt
	typedef enum logic [4:0] {
		XT_WRITE      = 5'b00010,
		// a cast-out write issued with gbl_n negated, nobody snoops it
		XT_SNOOP_PUSH = 5'b00110,
		XT_READ       = 5'b01010
	} xfer_type_t;

	// the two bus masters
	typedef enum logic {
		CPU1 = 1'b0,
		CPU2 = 1'b1
	} cpu_id_t;

endpackage

/* source/mem_bus_top.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module mem_bus_top (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   br1_n,
	input  logic                   br2_n,
	input  logic                   ts_n,
	input  bus_pkg::xfer_type_t    tt,
	input  logic                   gbl_n,
	input  logic [`BUS_ADDR_W-1:0] addr,
	input  logic                   artry_n,
	input  logic                   dbb_n,
	input  logic [`BUS_DATA_W-1:0] wdata,
	output logic                   bg1_n,
	output logic                   bg2_n,
	output logic                   dbg1_n,
	output logic                   dbg2_n,
	output logic                   aack_n,
	output logic                   ta_n,
	output logic                   drtry_n,
	output logic [`BUS_DATA_W-1:0] rdata
);

	// write data captured at ta_n, committed by the store
	logic [`BUS_DATA_W-1:0] wdata_q;
	logic                   queue_full;

	tenure_if  ten_bus ();
	mem_req_if req_bus ();

	bus_arbiter bus_arbiter_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.br1_n       (br1_n),
		.br2_n       (br2_n),
		.ts_n        (ts_n),
		.dbb_n       (dbb_n),
		.bg1_n       (bg1_n),
		.bg2_n       (bg2_n),
		.dbg1_n      (dbg1_n),
		.dbg2_n      (dbg2_n),
		.ten         (ten_bus.arb),
		.pending     (req_bus.pending),
		.head_master (req_bus.head_master),
		.queue_full  (queue_full)
	);

	mem_target mem_target_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.ts_n    (ts_n),
		.tt      (tt),
		.gbl_n   (gbl_n),
		.addr    (addr),
		.artry_n (artry_n),
		.dbb_n   (dbb_n),
		.wdata   (wdata),
		.aack_n  (aack_n),
		.ta_n    (ta_n),
		.drtry_n (drtry_n),
		.wdata_q (wdata_q),
		.ten     (ten_bus.tgt),
		.req     (req_bus.tgt)
	);

	mem_store mem_store_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.wdata_q    (wdata_q),
		.rdata      (rdata),
		.queue_full (queue_full),
		.req        (req_bus.store)
	);

endmodule

/* source/mem_req_if.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

// the target queues acknowledged address tenures here and retires them on data completion
interface mem_req_if;
	import bus_pkg::*;

	logic                   push;
	logic [`BUS_ADDR_W-1:0] push_addr;
	logic                   push_write;
	// master that asserted ts_n for the tenure being queued
	cpu_id_t                push_master;
	logic                   commit;
	// at least one tenure is waiting for its data beat
	logic                   pending;
	cpu_id_t                head_master;
	// raw memory word at the head address
	logic [`BUS_DATA_W-1:0] rdata;

	modport tgt (
		output push, push_addr, push_write, push_master, commit,
		input  pending, head_master, rdata
	);

	modport store (
		input  push, push_addr, push_write, push_master, commit,
		output pending, head_master, rdata
	);

endinterface

/* source/mem_store.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module mem_store (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [`BUS_DATA_W-1:0] wdata_q,
	output logic [`BUS_DATA_W-1:0] rdata,
	output logic                   queue_full,
	mem_req_if.store               req
);
	import bus_pkg::*;

	logic [`BUS_DATA_W-1:0] mem [0:`MEM_DEPTH-1];
	// two tenure slots used as a ring
	logic [`BUS_ADDR_W-1:0] q_addr [0:1];
	logic                   q_write [0:1];
	cpu_id_t                q_master [0:1];
	logic                   wr_ptr;
	logic                   rd_ptr;
	logic [1:0]             count;

	assign req.pending     = (count != 2'd0);
	assign req.head_master = q_master[rd_ptr];
	assign req.rdata       = mem[q_addr[rd_ptr]];
	assign queue_full      = (count == 2'd2);

	// the bus only carries memory contents while the head tenure is a read
	assign rdata = (req.pending && !q_write[rd_ptr]) ? req.rdata : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (req.push)
				wr_ptr <= ~wr_ptr;
			if (req.commit)
				rd_ptr <= ~rd_ptr;
			// a push and a retire may land in the same cycle
			case ({req.push, req.commit})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req.push) begin
			q_addr[wr_ptr]   <= req.push_addr;
			q_write[wr_ptr]  <= req.push_write;
			// the tenure being queued belongs to whoever asserted its ts_n
			q_master[wr_ptr] <= req.push_master;
		end
		// a write lands in memory only once its beat completed without retry
		if (req.commit && q_write[rd_ptr])
			mem[q_addr[rd_ptr]] <= wdata_q;
	end

endmodule

/* source/mem_target.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module mem_target (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   ts_n,
	input  bus_pkg::xfer_type_t    tt,
	input  logic                   gbl_n,
	input  logic [`BUS_ADDR_W-1:0] addr,
	input  logic                   artry_n,
	input  logic                   dbb_n,
	input  logic [`BUS_DATA_W-1:0] wdata,
	output logic                   aack_n,
	output logic                   ta_n,
	output logic                   drtry_n,
	output logic [`BUS_DATA_W-1:0] wdata_q,
	tenure_if.tgt                  ten,
	mem_req_if.tgt                 req
);
	import bus_pkg::*;

	addr_state_t            state;
	// cycles since ts_n, saturating at the acknowledge window
	logic [3:0]             age;
	logic                   hold_ta;
	logic [15:0]            lfsr;
	logic                   lfsr_fb;
	cpu_id_t                addr_master_q;
	cpu_id_t                cur_addr_master;
	logic [`BUS_ADDR_W-1:0] addr_q;
	logic                   write_q;
	logic                   ta_pick_n;
	logic                   ta_prev_n;
	logic                   hold_now;
	logic                   valid_artry;
	logic                   must_delay;
	logic                   window_next;

	// x^16 + x^14 + x^13 + x^11 stands in for the nondeterministic wait-state choice
	assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
	assign window_next = (age + 4'd1) >= 4'(`AACK_MIN_DELAY);

	// a master asserting ts_n right now already counts as the address master
	assign cur_addr_master = !ts_n ? ten.addr_master : addr_master_q;

	// the register only covers cycles after ts_n, so the ts_n cycle is decoded here
	assign hold_now = hold_ta ||
		(state == IDLE && !ts_n && tt != XT_SNOOP_PUSH && !gbl_n);
	assign valid_artry = !artry_n && (ten.data_master == cur_addr_master);
	// a different data master means its snoop window is long gone
	assign must_delay = hold_now && (ten.data_master == cur_addr_master);

	assign aack_n = (state != AACK);
	// ta_n never comes twice in a row, the gap is where drtry_n can appear
	assign ta_n = ((!dbb_n || !drtry_n) && !valid_artry && !must_delay && ta_prev_n) ?
		ta_pick_n : 1'b1;

	assign ten.addr_done = (state == AACK);
	assign ten.data_done = !ta_prev_n && drtry_n;
	// an address retry in the acknowledge cycle kills the tenure before it is queued
	assign req.push        = (state == AACK) && artry_n;
	assign req.push_addr   = addr_q;
	assign req.push_write  = write_q;
	// the master captured at ts_n owns the queued tenure
	assign req.push_master = addr_master_q;
	assign req.commit      = !ta_prev_n && drtry_n;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= IDLE;
			age           <= 4'd0;
			hold_ta       <= 1'b0;
			addr_master_q <= CPU1;
		end else begin
			if (age < 4'(`AACK_MIN_DELAY))
				age <= age + 4'd1;
			if (hold_ta && window_next)
				hold_ta <= 1'b0;
			case (state)
				IDLE: begin
					if (!ts_n) begin
						state         <= DELAY;
						age           <= 4'd1;
						hold_ta       <= (tt != XT_SNOOP_PUSH) && !gbl_n;
						addr_master_q <= ten.addr_master;
					end
				end
				DELAY:
					state <= AACK_WAIT;
				AACK_WAIT: begin
					// lfsr bit 0 set means one more wait state
					if (window_next && !lfsr[0])
						state <= AACK;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr      <= `LFSR_SEED;
			ta_pick_n <= 1'b1;
			ta_prev_n <= 1'b1;
			drtry_n   <= 1'b1;
		end else begin
			lfsr      <= {lfsr[14:0], lfsr_fb};
			// ta_n is offered in roughly three cycles out of four
			ta_pick_n <= lfsr[5] & lfsr[9];
			ta_prev_n <= ta_n;
			if (valid_artry)
				drtry_n <= 1'b1;
			else if (!ta_n)
				drtry_n <= ~(lfsr[3] & lfsr[11]);
			else if (!drtry_n)
				// drtry_n stays low until the beat is sent again
				drtry_n <= 1'b0;
			else
				drtry_n <= 1'b1;
		end
	end

	// tenure attributes and write data are captured with the bus strobes
	always_ff @(posedge clk) begin
		if (state == IDLE && !ts_n) begin
			addr_q  <= addr;
			write_q <= (tt == XT_WRITE) || (tt == XT_SNOOP_PUSH);
		end
		if (!ta_n)
			wdata_q <= wdata;
	end

endmodule

/* source/tenure_if.sv */
`timescale 1ns/1ps

// bus ownership flows from the arbiter to the target and tenure completion flows back
interface tenure_if;
	import bus_pkg::*;

	// master holding the most recent address grant
	cpu_id_t addr_master;
	// master that took the data bus for the current data tenure
	cpu_id_t data_master;
	// one cycle pulse in the aack_n cycle
	logic addr_done;
	// one cycle pulse when a data beat finished without drtry_n
	logic data_done;

	modport arb (
		output addr_master,
		output data_master,
		input  addr_done,
		input  data_done
	);

	modport tgt (
		input  addr_master,
		input  data_master,
		output addr_done,
		output data_done
	);

endinterface

/* tests/tb_mem_bus.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module tb_mem_bus;
	import bus_pkg::*;

	localparam int CLK_PERIOD = 100;
	// acknowledged address tenures over both CPUs
	localparam int N_TX       = 60;
	localparam int ADDR_W     = `BUS_ADDR_W;

	// one acknowledged tenure waiting for its data beat
	typedef struct packed {
		cpu_id_t           master;
		logic [ADDR_W-1:0] addr;
		logic              write;
	} tenure_t;

	logic                   clk;
	logic                   arst_n;
	logic                   br1_n;
	logic                   br2_n;
	logic                   ts_n;
	xfer_type_t             tt;
	logic                   gbl_n;
	logic [ADDR_W-1:0]      addr;
	logic                   artry_n;
	logic                   dbb_n;
	logic [`BUS_DATA_W-1:0] wdata;
	logic                   bg1_n;
	logic                   bg2_n;
	logic                   dbg1_n;
	logic                   dbg2_n;
	logic                   aack_n;
	logic                   ta_n;
	logic                   drtry_n;
	logic [`BUS_DATA_W-1:0] rdata;

	// reference memory, only words written during the run are compared
	logic [`BUS_DATA_W-1:0] model_mem [0:`MEM_DEPTH-1];
	bit                     written [0:`MEM_DEPTH-1];
	tenure_t                tq [$];
	// latest address tenure and whether it holds ta_n back
	tenure_t                cur;
	bit                     cur_hold;
	bit                     ten_open;
	int                     ts_cycle;
	int                     cycle;
	cpu_id_t                last_grant;
	bit                     have_grant;
	cpu_id_t                data_owner;
	logic [`BUS_DATA_W-1:0] ta_wdata;
	// bus levels seen at the previous falling edge
	bit                     ta_seen;
	bit                     drtry_seen;
	bit                     artry_valid_seen;
	logic                   bg1_q;
	logic                   bg2_q;
	logic                   dbg1_q;
	logic                   dbg2_q;
	logic                   br1_q;
	logic                   br2_q;
	int                     issued [2];
	int                     checks;
	int                     value_errors;
	int                     protocol_errors;

	mem_bus_top mem_bus_top_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.br1_n   (br1_n),
		.br2_n   (br2_n),
		.ts_n    (ts_n),
		.tt      (tt),
		.gbl_n   (gbl_n),
		.addr    (addr),
		.artry_n (artry_n),
		.dbb_n   (dbb_n),
		.wdata   (wdata),
		.bg1_n   (bg1_n),
		.bg2_n   (bg2_n),
		.dbg1_n  (dbg1_n),
		.dbg2_n  (dbg2_n),
		.aack_n  (aack_n),
		.ta_n    (ta_n),
		.drtry_n (drtry_n),
		.rdata   (rdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_word(input string name, input logic [`BUS_DATA_W-1:0] exp,
			input logic [`BUS_DATA_W-1:0] act);
		checks++;
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_cpu(input string name, input cpu_id_t exp, input cpu_id_t act);
		checks++;
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic report_violation(input string msg);
		protocol_errors++;
		$display("cycle %0d: %s", cycle, msg);
	endtask

	task automatic print_summary();
		$display("checks %0d, value errors %0d, protocol errors %0d",
			checks, value_errors, protocol_errors);
	endtask

	task automatic drive_request(input cpu_id_t id, input logic level);
		if (id == CPU1)
			br1_n = level;
		else
			br2_n = level;
	endtask

	// one bus master, acting a little after each rising edge
	task automatic run_cpu(input cpu_id_t id);
		logic bg;
		logic dbg;
		logic br;
		bit   wait_aack;
		bit   ts_mine;
		bit   artry_mine;
		bit   owns;
		bit   dbg_was_low;
		wait_aack   = 0;
		ts_mine     = 0;
		artry_mine  = 0;
		owns        = 0;
		dbg_was_low = 0;
		forever begin
			@(posedge clk);
			#5;
			bg  = (id == CPU1) ? bg1_n : bg2_n;
			dbg = (id == CPU1) ? dbg1_n : dbg2_n;
			br  = (id == CPU1) ? br1_n : br2_n;
			if (ts_mine) begin
				ts_n    = 1'b1;
				ts_mine = 0;
			end
			if (artry_mine) begin
				artry_n    = 1'b1;
				artry_mine = 0;
			end
			if (wait_aack && !aack_n) begin
				wait_aack = 0;
				// an occasional retry cancels the tenure and the CPU asks again
				if ($urandom_range(7) == 0) begin
					artry_n    = 1'b0;
					artry_mine = 1;
				end else
					issued[int'(id)]++;
			end else if (!wait_aack && issued[int'(id)] < N_TX / 2) begin
				if (!bg) begin
					drive_request(id, 1'b1);
					case ($urandom_range(2))
						0:       tt = XT_WRITE;
						1:       tt = XT_READ;
						default: tt = XT_SNOOP_PUSH;
					endcase
					// a small address range makes reads hit earlier writes
					addr      = ADDR_W'($urandom_range(15));
					gbl_n     = (tt == XT_SNOOP_PUSH) ? 1'b1 : 1'($urandom_range(1));
					ts_n      = 1'b0;
					ts_mine   = 1;
					wait_aack = 1;
				end else if (br && $urandom_range(3) == 0)
					drive_request(id, 1'b0);
			end
			if (owns) begin
				// the beat is over once ta_n came and no drtry_n followed it
				if (ta_seen && drtry_n) begin
					dbb_n = 1'b1;
					owns  = 0;
				end else
					wdata = $urandom;
			end else if (!dbg && dbg_was_low && tq.size() != 0) begin
				// dbb_n goes low in the second grant cycle
				dbb_n = 1'b0;
				owns  = 1;
				wdata = $urandom;
			end
			dbg_was_low = !dbg;
		end
	endtask

	// reference model and protocol checks, sampled where all levels are settled
	always @(negedge clk) begin
		tenure_t done_ten;
		cpu_id_t act;
		if (arst_n) begin
			cycle++;
			if (!bg1_n && !bg2_n)
				report_violation("both address grants are low");
			if ((!bg1_n && bg1_q) || (!bg2_n && bg2_q)) begin
				act = !bg1_n ? CPU1 : CPU2;
				// with both CPUs asking the winner alternates
				if (!br1_q && !br2_q && have_grant)
					check_cpu("address grant", (last_grant == CPU1) ? CPU2 : CPU1, act);
				last_grant = act;
				have_grant = 1;
			end
			if ((!dbg1_n && dbg1_q) || (!dbg2_n && dbg2_q)) begin
				act        = !dbg1_n ? CPU1 : CPU2;
				data_owner = act;
				if (tq.size() == 0)
					report_violation("data bus granted with no tenure queued");
				else
					check_cpu("data grant", tq[0].master, act);
			end
			if (!drtry_n && !ta_seen && !drtry_seen)
				report_violation("drtry_n asserted without a ta_n before it");
			if (artry_valid_seen)
				check_bit("drtry_n after address retry", 1'b1, drtry_n);
			if (ta_seen && drtry_n) begin
				if (tq.size() == 0)
					report_violation("data beat completed with no tenure queued");
				else begin
					done_ten = tq.pop_front();
					if (done_ten.write) begin
						model_mem[done_ten.addr] = ta_wdata;
						written[done_ten.addr]   = 1;
					end else if (written[done_ten.addr])
						check_word("read data", model_mem[done_ten.addr], rdata);
				end
			end
			if (!ts_n) begin
				if (ten_open)
					report_violation("ts_n accepted before the previous aack_n");
				ten_open   = 1;
				ts_cycle   = cycle;
				cur.master = last_grant;
				cur.addr   = addr;
				cur.write  = (tt != XT_READ);
				// a snoop push is never snooped so it never holds ta_n back
				cur_hold   = (tt != XT_SNOOP_PUSH) && !gbl_n;
			end
			if (!aack_n) begin
				if (!ten_open)
					report_violation("aack_n without an open address tenure");
				else if (cycle - ts_cycle < `AACK_MIN_DELAY)
					report_violation("aack_n came too soon after ts_n");
				ten_open = 0;
				if (artry_n)
					tq.push_back(cur);
			end
			if (!ta_n) begin
				if (dbb_n && drtry_n)
					report_violation("ta_n asserted with neither dbb_n nor drtry_n low");
				if (cur_hold && data_owner == cur.master && cycle - ts_cycle < `AACK_MIN_DELAY)
					report_violation("ta_n inside the acknowledge window of a snooped tenure");
				ta_wdata = wdata;
			end
			ta_seen          = !ta_n;
			drtry_seen       = !drtry_n;
			artry_valid_seen = !artry_n && data_owner == cur.master;
			bg1_q            = bg1_n;
			bg2_q            = bg2_n;
			dbg1_q           = dbg1_n;
			dbg2_q           = dbg2_n;
			br1_q            = br1_n;
			br2_q            = br2_n;
		end
	end

	// the longest legal run is well below forty cycles per tenure
	initial begin
		#((N_TX * 40 + 4) * CLK_PERIOD);
		$display("run stopped after %0d cycles with tenures still outstanding", N_TX * 40);
		print_summary();
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(32'h39cd_0cd3));
		clk     = 1'b0;
		arst_n  = 1'b0;
		br1_n   = 1'b1;
		br2_n   = 1'b1;
		ts_n    = 1'b1;
		tt      = XT_READ;
		gbl_n   = 1'b1;
		addr    = '0;
		artry_n = 1'b1;
		dbb_n   = 1'b1;
		wdata   = '0;
		cur     = '0;
		cycle   = 0;
		// far in the past so no window is open at start
		ts_cycle        = -1000;
		ten_open        = 0;
		have_grant      = 0;
		data_owner      = CPU1;
		ta_seen         = 0;
		drtry_seen      = 0;
		artry_valid_seen = 0;
		bg1_q           = 1'b1;
		bg2_q           = 1'b1;
		dbg1_q          = 1'b1;
		dbg2_q          = 1'b1;
		br1_q           = 1'b1;
		br2_q           = 1'b1;
		issued[0]       = 0;
		issued[1]       = 0;
		checks          = 0;
		value_errors    = 0;
		protocol_errors = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_bit("bg1_n in reset", 1'b1, bg1_n);
		check_bit("bg2_n in reset", 1'b1, bg2_n);
		check_bit("dbg1_n in reset", 1'b1, dbg1_n);
		check_bit("dbg2_n in reset", 1'b1, dbg2_n);
		check_bit("aack_n in reset", 1'b1, aack_n);
		check_bit("ta_n in reset", 1'b1, ta_n);
		check_bit("drtry_n in reset", 1'b1, drtry_n);
		@(posedge clk);
		#5;
		arst_n = 1'b1;
		fork
			run_cpu(CPU1);
			run_cpu(CPU2);
		join_none
		// every tenure acknowledged and every data beat retired
		while (issued[0] + issued[1] < N_TX || tq.size() != 0 || ten_open || !dbb_n)
			@(posedge clk);
		repeat (4) @(posedge clk);
		print_summary();
		if (value_errors == 0 && protocol_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
